// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fpu_cluster_tb
FILELIST  ?= fpu_cluster.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== fpu_cluster.f ====
verilog/fpu_pkg.sv
verilog/fpu_lane_if.sv
verilog/fpu_issue_ctrl.sv
verilog/fpu_lane.sv
verilog/fp_to_int_cvt.sv
verilog/fpu_cluster.sv
testbench/fpu_cluster_asserts.sv
testbench/fpu_cluster_tb.sv

// ==== testbench/fpu_cluster_asserts.sv ====
`timescale 1ns/1ns

module fpu_cluster_asserts #(
  parameter int NUM_LANES = 3
) (
  input logic                             clk,
  input logic                             rst_n,
  input logic             [NUM_LANES-1:0] lane_en,
  input fpu_pkg::fpu_op_e [NUM_LANES-1:0] lane_op,
  input logic             [NUM_LANES-1:0] lane_res_en,
  input logic                             cvt_res_en,
  input logic                             flag_clr,
  input logic                             flag_invalid,
  input logic                             flag_inexact
);
  import fpu_pkg::*;

  logic [NUM_LANES-1:0] lane_issue;
  logic                 cvt_issue;

  // One result enable per issued lane op, one cycle later.
  for (genvar gi = 0; gi < NUM_LANES; gi++) begin : g_lane
    assign lane_issue[gi] = lane_en[gi] &&
                            (lane_op[gi] inside {OP_ABS, OP_NEG, OP_MIN, OP_MAX, OP_CMPLT});

    a_lane_res_en : assert property (@(posedge clk) disable iff (!rst_n)
      lane_res_en[gi] == $past(lane_issue[gi]))
      else $error("lane_res_en[%0d] does not follow its issue", gi);
  end

  assign cvt_issue = lane_en[NUM_LANES-1] && (lane_op[NUM_LANES-1] == OP_CVT);

  a_cvt_res_en : assert property (@(posedge clk) disable iff (!rst_n)
    cvt_res_en == $past(cvt_issue, 2))
    else $error("cvt_res_en does not follow a conversion two cycles back");

  a_invalid_sticky : assert property (@(posedge clk) disable iff (!rst_n)
    $fell(flag_invalid) |-> $past(flag_clr))
    else $error("flag_invalid fell without flag_clr");

  a_inexact_sticky : assert property (@(posedge clk) disable iff (!rst_n)
    $fell(flag_inexact) |-> $past(flag_clr))
    else $error("flag_inexact fell without flag_clr");

endmodule

bind fpu_cluster fpu_cluster_asserts #(
  .NUM_LANES (NUM_LANES)
) i_fpu_cluster_asserts (
  .clk          (clk),
  .rst_n        (rst_n),
  .lane_en      (lane_en),
  .lane_op      (lane_op),
  .lane_res_en  (lane_res_en),
  .cvt_res_en   (cvt_res_en),
  .flag_clr     (flag_clr),
  .flag_invalid (flag_invalid),
  .flag_inexact (flag_inexact)
);

// ==== testbench/fpu_cluster_tb.sv ====
`timescale 1ns/1ns

module fpu_cluster_tb;
  import fpu_pkg::*;

  localparam int NUM_LANES  = 3;
  localparam int CLK_PERIOD = 20;
  localparam int MAX_TESTS  = 256;

  localparam logic [3:0] LINK_SAME = 4'h1;
  localparam logic [3:0] LINK_NEXT = 4'h2;
  localparam logic [3:0] LINK_END  = 4'hf;

  typedef struct packed {
    logic [3:0]  link;
    logic [3:0]  lane;
    logic [3:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [3:0]  rnd;
    logic [3:0]  clr;
    logic [31:0] res;
    logic [3:0]  flags;
  } test_rec_t;

  logic                     clk;
  logic                     rst_n;
  logic     [NUM_LANES-1:0] lane_en;
  fpu_op_e  [NUM_LANES-1:0] lane_op;
  fp_word_t [NUM_LANES-1:0] lane_a;
  fp_word_t [NUM_LANES-1:0] lane_b;
  rnd_mode_e                rnd_mode;
  logic                     flag_clr;
  fp_word_t [NUM_LANES-1:0] lane_res;
  logic     [NUM_LANES-1:0] lane_res_en;
  fp_word_t                 cvt_res;
  logic                     cvt_res_en;
  logic                     flag_invalid;
  logic                     flag_inexact;

  logic [119:0] test_mem [MAX_TESTS];
  int           num_tests;
  logic         tests_loaded = 1'b0;
  integer       seed = 97756;
  int           checks = 0;
  int           errors = 0;

  // Expected results in issue order and the sticky flags {invalid, inexact}.
  fp_word_t   lane_q [NUM_LANES][$];
  fp_word_t   cvt_res_q [$];
  logic [1:0] cvt_flag_q [$];
  logic [1:0] flag_model = 2'b00;

  fpu_cluster #(
    .NUM_LANES (NUM_LANES)
  ) i_fpu_cluster (
    .clk          (clk),
    .rst_n        (rst_n),
    .lane_en      (lane_en),
    .lane_op      (lane_op),
    .lane_a       (lane_a),
    .lane_b       (lane_b),
    .rnd_mode     (rnd_mode),
    .flag_clr     (flag_clr),
    .lane_res     (lane_res),
    .lane_res_en  (lane_res_en),
    .cvt_res      (cvt_res),
    .cvt_res_en   (cvt_res_en),
    .flag_invalid (flag_invalid),
    .flag_inexact (flag_inexact)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // Only lane ops and conversions on the last lane produce a result.
  task automatic expect_result(test_rec_t rec);
    if (fpu_op_e'(rec.op) == OP_CVT && int'(rec.lane) == NUM_LANES - 1) begin
      cvt_res_q.push_back(rec.res);
      cvt_flag_q.push_back(rec.flags[1:0]);
    end else if (fpu_op_e'(rec.op) inside {OP_ABS, OP_NEG, OP_MIN, OP_MAX, OP_CMPLT}) begin
      lane_q[int'(rec.lane)].push_back(rec.res);
    end
  endtask

  task automatic drive_idle_slot();
    int nop_lane;
    nop_lane = $unsigned($random(seed)) % NUM_LANES;
    lane_en  <= '0;
    flag_clr <= 1'b0;
    if ($random(seed) & 1) begin
      lane_en[nop_lane] <= 1'b1;
      lane_op[nop_lane] <= OP_NOP;
    end
  endtask

  function automatic int pending_results();
    int n;
    n = cvt_res_q.size();
    for (int i = 0; i < NUM_LANES; i++) begin
      n += lane_q[i].size();
    end
    return n;
  endfunction

  task automatic run_tests();
    test_rec_t                rec;
    logic     [NUM_LANES-1:0] en_v;
    fpu_op_e  [NUM_LANES-1:0] op_v;
    fp_word_t [NUM_LANES-1:0] a_v;
    fp_word_t [NUM_LANES-1:0] b_v;
    rnd_mode_e                rnd_v;
    logic                     clr_v;
    logic     [3:0]           link;
    int                       idx;
    int                       ln;
    idx  = 0;
    link = 4'h0;
    while (idx < num_tests) begin
      // No random idle or NOP slots inside a back-to-back pair.
      if (link != LINK_NEXT) begin
        repeat ($unsigned($random(seed)) % 2) begin
          @(posedge clk);
          drive_idle_slot();
        end
      end
      en_v  = '0;
      op_v  = lane_op;
      a_v   = lane_a;
      b_v   = lane_b;
      rnd_v = rnd_mode;
      clr_v = 1'b0;
      do begin
        rec      = test_rec_t'(test_mem[idx]);
        ln       = int'(rec.lane);
        link     = rec.link;
        idx++;
        en_v[ln] = 1'b1;
        op_v[ln] = fpu_op_e'(rec.op);
        a_v[ln]  = rec.a;
        b_v[ln]  = rec.b;
        if (fpu_op_e'(rec.op) == OP_CVT) begin
          rnd_v = rnd_mode_e'(rec.rnd[0]);
        end
        clr_v = clr_v | rec.clr[0];
        expect_result(rec);
      end while (link == LINK_SAME && idx < num_tests);
      @(posedge clk);
      lane_en  <= en_v;
      lane_op  <= op_v;
      lane_a   <= a_v;
      lane_b   <= b_v;
      rnd_mode <= rnd_v;
      flag_clr <= clr_v;
    end
    @(posedge clk);
    lane_en  <= '0;
    flag_clr <= 1'b0;
  endtask

  // ####################
  // Stimulus and end of run.
  // ####################
  initial begin : stimulus
    logic found;
    found    = 1'b0;
    rst_n    = 1'b0;
    lane_en  = '0;
    lane_a   = '0;
    lane_b   = '0;
    rnd_mode = RND_TRUNC;
    flag_clr = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_op[i] = OP_NOP;
    end
    $readmemh("testbench/fpu_cluster_tests.txt", test_mem);
    num_tests = 0;
    for (int i = 0; i < MAX_TESTS; i++) begin
      if (!found && test_mem[i][119:116] == LINK_END) begin
        found     = 1'b1;
        num_tests = i;
      end
    end
    tests_loaded = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    if (!found) begin
      $display("Test file has no end marker");
      $display("TEST FAIL");
      $finish;
    end else begin
      run_tests();
      while (pending_results() != 0) begin
        @(posedge clk);
      end
      // Let the last flag update land.
      repeat (2) @(posedge clk);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
      $finish;
    end
  end

  // ####################
  // Result and flag checks.
  // ####################
  always @(negedge clk) begin : monitor
    fp_word_t   exp_word;
    logic [1:0] new_flags;
    new_flags = 2'b00;
    if (rst_n) begin
      checks += 2;
      if (flag_invalid !== flag_model[1]) begin
        errors++;
        $display("Fail %0t: flag_invalid got %b, expected %b", $time, flag_invalid,
                 flag_model[1]);
      end
      if (flag_inexact !== flag_model[0]) begin
        errors++;
        $display("Fail %0t: flag_inexact got %b, expected %b", $time, flag_inexact,
                 flag_model[0]);
      end
      for (int i = 0; i < NUM_LANES; i++) begin
        if (lane_res_en[i]) begin
          if (lane_q[i].size() == 0) begin
            errors++;
            $display("Lane %0d gave a result at %0t with none expected", i, $time);
          end else begin
            exp_word = lane_q[i].pop_front();
            checks++;
            if (lane_res[i] !== exp_word) begin
              errors++;
              $display("Fail %0t: lane_res[%0d] got %h, expected %h", $time, i,
                       lane_res[i], exp_word);
            end
          end
        end
      end
      if (cvt_res_en) begin
        if (cvt_res_q.size() == 0) begin
          errors++;
          $display("Converter gave a result at %0t with none expected", $time);
        end else begin
          exp_word  = cvt_res_q.pop_front();
          new_flags = cvt_flag_q.pop_front();
          checks++;
          if (cvt_res !== exp_word) begin
            errors++;
            $display("Fail %0t: cvt_res got %h, expected %h", $time, cvt_res, exp_word);
          end
        end
      end
      // A flag arriving with the clear is kept.
      flag_model = (flag_model & ~{2{flag_clr}}) | new_flags;
    end
  end

  initial begin : watchdog
    wait (tests_loaded);
    #((num_tests + 20) * 2 * CLK_PERIOD);
    $display("Timeout after %0t, results still outstanding", $time);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== testbench/fpu_cluster_tests.txt ====
// link_lane_op_a_b_rnd_clr_result_flags (flags: bit1 invalid, bit0 inexact)
// link 1 = same cycle as next record, 2 = next record in the next cycle, f = end
0_0_1_c0490fdb_00000000_0_0_40490fdb_0
0_1_2_3f800000_00000000_0_0_bf800000_0
0_2_2_80000000_00000000_0_0_00000000_0
0_0_3_80000000_00000000_0_0_80000000_0
0_1_4_80000000_00000000_0_0_00000000_0
0_2_5_80000000_00000000_0_0_00000001_0
0_0_5_00000000_80000000_0_0_00000000_0
0_1_3_3f800000_3f800000_0_0_3f800000_0
0_1_5_3f800000_3f800000_0_0_00000000_0
0_2_3_c0000000_bf800000_0_0_c0000000_0
0_0_4_c0000000_40400000_0_0_40400000_0
2_2_6_3fc00000_00000000_0_0_00000001_1
2_2_6_3fc00000_00000000_1_0_00000002_1
2_2_6_40200000_00000000_1_0_00000002_1
0_2_6_40600000_00000000_1_0_00000004_1
0_2_6_c0600000_00000000_1_0_fffffffc_1
0_2_6_42f60000_00000000_0_0_0000007b_0
0_0_6_3fc00000_00000000_0_0_00000000_0
0_1_0_3fc00000_00000000_0_0_00000000_0
0_1_0_00000000_00000000_0_1_00000000_0
0_2_6_3f000000_00000000_1_0_00000000_1
0_2_6_3e800000_00000000_0_0_00000000_1
0_2_6_4f000000_00000000_0_0_7fffffff_2
0_2_6_cf000000_00000000_0_0_80000000_0
0_2_6_ff800000_00000000_0_0_80000000_2
0_2_6_7fc00000_00000000_0_0_7fffffff_2
0_2_6_7f800000_00000000_0_0_7fffffff_2
0_2_6_00000000_00000000_0_1_00000000_0
1_0_1_c1200000_00000000_0_0_41200000_0
1_1_3_40a00000_c0a00000_0_0_c0a00000_0
0_2_6_40a00000_00000000_0_0_00000005_0
0_0_0_00000000_00000000_0_1_00000000_0
f_0_0_00000000_00000000_0_0_00000000_0

// ==== verilog/fp_to_int_cvt.sv ====
`timescale 1ns/1ns

module fp_to_int_cvt (
  input  logic    clk,
  input  logic    rst_n,
  fpu_lane_if.cvt port
);
  import fpu_pkg::*;

  // Exponent where the top integer bit has weight 2^30.
  localparam logic [EXP_WIDTH-1:0] EXP_TOP  = EXP_WIDTH'(EXP_BIAS + 30);
  localparam logic [EXP_WIDTH-1:0] EXP_SAT  = EXP_WIDTH'(EXP_BIAS + 31);
  localparam logic [EXP_WIDTH-1:0] EXP_HALF = EXP_WIDTH'(EXP_BIAS - 1);

  logic                  sign_f;
  logic [EXP_WIDTH-1:0]  exp_f;
  logic [MANT_WIDTH-1:0] mant_f;
  logic [4:0]            rsh;
  logic [63:0]           wide;
  logic [63:0]           shifted;

  logic        sat_d, sat_max_d, invalid_d, guard_d, sticky_d;
  logic [30:0] int_d;

  logic        s1_valid;
  logic        s1_sign, s1_sat, s1_sat_max, s1_invalid, s1_guard, s1_sticky;
  logic [30:0] s1_int;
  rnd_mode_e   s1_rnd;

  logic     round_up;
  fp_word_t mag;
  fp_word_t res_d;

  // ####################
  // Stage 1, unpack and align.
  // ####################
  assign sign_f  = port.a[FP_WIDTH-1];
  assign exp_f   = port.a[FP_WIDTH-2 -: EXP_WIDTH];
  assign mant_f  = port.a[MANT_WIDTH-1:0];
  assign rsh     = 5'(EXP_TOP - exp_f);
  assign wide    = {1'b1, mant_f, 40'b0};
  assign shifted = wide >> rsh;

  // Integer in [63:33], guard at 32, sticky below.
  always_comb begin
    sat_d     = 1'b0;
    sat_max_d = 1'b0;
    invalid_d = 1'b0;
    guard_d   = 1'b0;
    sticky_d  = 1'b0;
    int_d     = '0;
    if (exp_f == '1) begin
      // NaN goes to the positive limit whatever its sign.
      sat_d     = 1'b1;
      invalid_d = 1'b1;
      sat_max_d = !sign_f || (mant_f != '0);
    end else if (exp_f >= EXP_SAT) begin
      sat_d     = 1'b1;
      sat_max_d = !sign_f;
      invalid_d = !(sign_f && (exp_f == EXP_SAT) && (mant_f == '0));
    end else if (exp_f >= EXP_HALF) begin
      int_d    = shifted[63:33];
      guard_d  = shifted[32];
      sticky_d = |shifted[31:0];
    end else begin
      sticky_d = (exp_f != '0) || (mant_f != '0);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= port.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (port.valid) begin
      s1_sign    <= sign_f;
      s1_sat     <= sat_d;
      s1_sat_max <= sat_max_d;
      s1_invalid <= invalid_d;
      s1_guard   <= guard_d;
      s1_sticky  <= sticky_d;
      s1_int     <= int_d;
      s1_rnd     <= port.rnd;
    end
  end

  // ####################
  // Stage 2, round and saturate.
  // ####################
  assign round_up = (s1_rnd == RND_NEAREST) && s1_guard && (s1_sticky || s1_int[0]);
  assign mag      = {1'b0, s1_int} + FP_WIDTH'(round_up);
  assign res_d    = s1_sat ? (s1_sat_max ? INT_MAX_WORD : INT_MIN_WORD)
                           : (s1_sign ? -mag : mag);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      port.res_valid <= 1'b0;
      port.res       <= '0;
      port.flags     <= '0;
    end else begin
      port.res_valid <= s1_valid;
      if (s1_valid) begin
        port.res           <= res_d;
        port.flags.invalid <= s1_invalid;
        port.flags.inexact <= !s1_sat && (s1_guard || s1_sticky);
      end else begin
        port.flags <= '0;
      end
    end
  end

endmodule

// ==== verilog/fpu_cluster.sv ====
`timescale 1ns/1ns

module fpu_cluster #(
  parameter int NUM_LANES = 3
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic              [NUM_LANES-1:0] lane_en,
  input  fpu_pkg::fpu_op_e  [NUM_LANES-1:0] lane_op,
  input  fpu_pkg::fp_word_t [NUM_LANES-1:0] lane_a,
  input  fpu_pkg::fp_word_t [NUM_LANES-1:0] lane_b,
  input  fpu_pkg::rnd_mode_e                rnd_mode,
  input  logic                              flag_clr,
  output fpu_pkg::fp_word_t [NUM_LANES-1:0] lane_res,
  output logic              [NUM_LANES-1:0] lane_res_en,
  output fpu_pkg::fp_word_t                 cvt_res,
  output logic                              cvt_res_en,
  output logic                              flag_invalid,
  output logic                              flag_inexact
);

  // One issue bundle per lane, plus the converter hanging off the last lane.
  fpu_lane_if i_lane_if [NUM_LANES] ();
  fpu_lane_if i_cvt_if ();

  // ####################
  // Issue control.
  // ####################
  fpu_issue_ctrl #(
    .NUM_LANES (NUM_LANES)
  ) i_fpu_issue_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .lane_en      (lane_en),
    .lane_op      (lane_op),
    .lane_a       (lane_a),
    .lane_b       (lane_b),
    .rnd_mode     (rnd_mode),
    .flag_clr     (flag_clr),
    .lanes        (i_lane_if),
    .cvt          (i_cvt_if),
    .cvt_ret      (i_cvt_if),
    .flag_invalid (flag_invalid),
    .flag_inexact (flag_inexact)
  );

  // ####################
  // Lanes.
  // ####################
  for (genvar gi = 0; gi < NUM_LANES; gi++) begin : g_lane
    fpu_lane i_fpu_lane (
      .clk    (clk),
      .rst_n  (rst_n),
      .issue  (i_lane_if[gi]),
      .res    (lane_res[gi]),
      .res_en (lane_res_en[gi])
    );
  end

  // ####################
  // Converter.
  // ####################
  fp_to_int_cvt i_fp_to_int_cvt (
    .clk   (clk),
    .rst_n (rst_n),
    .port  (i_cvt_if)
  );

  assign cvt_res    = i_cvt_if.res;
  assign cvt_res_en = i_cvt_if.res_valid;

endmodule

// ==== verilog/fpu_issue_ctrl.sv ====
`timescale 1ns/1ns

module fpu_issue_ctrl #(
  parameter int NUM_LANES = 3
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic              [NUM_LANES-1:0]      lane_en,
  input  fpu_pkg::fpu_op_e  [NUM_LANES-1:0]      lane_op,
  input  fpu_pkg::fp_word_t [NUM_LANES-1:0]      lane_a,
  input  fpu_pkg::fp_word_t [NUM_LANES-1:0]      lane_b,
  input  fpu_pkg::rnd_mode_e                     rnd_mode,
  input  logic                                   flag_clr,
  fpu_lane_if.ctrl                               lanes [NUM_LANES],
  fpu_lane_if.ctrl                               cvt,
  fpu_lane_if.ctrl                               cvt_ret,
  output logic                                   flag_invalid,
  output logic                                   flag_inexact
);
  import fpu_pkg::*;

  localparam int CVT_LANE = NUM_LANES - 1;

  logic cvt_issue;
  logic new_invalid;
  logic new_inexact;

  // Ops a lane executes itself. Anything else, unknown codes too, is no issue.
  function automatic logic is_lane_op(fpu_op_e op);
    logic ok;
    case (op)
      OP_ABS, OP_NEG, OP_MIN, OP_MAX, OP_CMPLT: ok = 1'b1;
      default:                                  ok = 1'b0;
    endcase
    return ok;
  endfunction

  // ####################
  // Lane issue.
  // ####################
  for (genvar gi = 0; gi < NUM_LANES; gi++) begin : g_issue
    assign lanes[gi].valid = lane_en[gi] && is_lane_op(lane_op[gi]);
    assign lanes[gi].op    = lane_op[gi];
    assign lanes[gi].a     = lane_a[gi];
    assign lanes[gi].b     = lane_b[gi];
    assign lanes[gi].rnd   = rnd_mode;
  end

  // ####################
  // Converter issue.
  // ####################
  // Only the last lane may convert; OP_CVT elsewhere is silently dropped.
  assign cvt_issue = lane_en[CVT_LANE] && (lane_op[CVT_LANE] == OP_CVT);

  assign cvt.valid = cvt_issue;
  assign cvt.op    = OP_CVT;
  assign cvt.a     = lane_a[CVT_LANE];
  assign cvt.b     = lane_b[CVT_LANE];
  assign cvt.rnd   = rnd_mode;

  // ####################
  // Sticky flags.
  // ####################
  assign new_invalid = cvt_ret.res_valid && cvt_ret.flags.invalid;
  assign new_inexact = cvt_ret.res_valid && cvt_ret.flags.inexact;

  // A flag arriving with the clear survives it.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flag_invalid <= 1'b0;
      flag_inexact <= 1'b0;
    end else begin
      flag_invalid <= (flag_invalid && !flag_clr) || new_invalid;
      flag_inexact <= (flag_inexact && !flag_clr) || new_inexact;
    end
  end

endmodule

// ==== verilog/fpu_lane.sv ====
`timescale 1ns/1ns

module fpu_lane (
  input  logic              clk,
  input  logic              rst_n,
  fpu_lane_if.lane          issue,
  output fpu_pkg::fp_word_t res,
  output logic              res_en
);
  import fpu_pkg::*;

  localparam int SIGN = FP_WIDTH - 1;

  fp_word_t key_a;
  fp_word_t key_b;
  logic     a_lt_b;
  logic     b_lt_a;
  fp_word_t res_d;

  // Map sign-magnitude onto an unsigned key with the same order.
  // -0 lands just below +0.
  function automatic fp_word_t order_key(fp_word_t x);
    fp_word_t k;
    if (x[SIGN]) begin
      k = ~x;
    end else begin
      k = {1'b1, x[SIGN-1:0]};
    end
    return k;
  endfunction

  assign key_a  = order_key(issue.a);
  assign key_b  = order_key(issue.b);
  assign a_lt_b = key_a < key_b;
  assign b_lt_a = key_b < key_a;

  // ####################
  // Operation select.
  // ####################
  always_comb begin
    res_d = '0;
    case (issue.op)
      OP_ABS: begin
        res_d = {1'b0, issue.a[SIGN-1:0]};
      end
      OP_NEG: begin
        res_d = {~issue.a[SIGN], issue.a[SIGN-1:0]};
      end
      OP_MIN: begin
        // Ties keep a.
        res_d = b_lt_a ? issue.b : issue.a;
      end
      OP_MAX: begin
        res_d = a_lt_b ? issue.b : issue.a;
      end
      OP_CMPLT: begin
        res_d = FP_WIDTH'(a_lt_b);
      end
      default: begin
        res_d = '0;
      end
    endcase
  end

  // ####################
  // Result register.
  // ####################
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_en <= 1'b0;
    end else begin
      res_en <= issue.valid;
    end
  end

  // Result only moves on an issue; zero out of reset.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res <= '0;
    end else if (issue.valid) begin
      res <= res_d;
    end
  end

endmodule

// ==== verilog/fpu_lane_if.sv ====
`timescale 1ns/1ns

interface fpu_lane_if;
  import fpu_pkg::*;

  // Issue side.
  logic      valid;
  fpu_op_e   op;
  fp_word_t  a;
  fp_word_t  b;
  rnd_mode_e rnd;

  // Return side, used by the converter only.
  fp_word_t   res;
  logic       res_valid;
  cvt_flags_t flags;

  modport ctrl (
    output valid, op, a, b, rnd,
    input  res_valid, flags
  );

  modport lane (
    input valid, op, a, b
  );

  modport cvt (
    input  valid, a, rnd,
    output res, res_valid, flags
  );

endinterface

// ==== verilog/fpu_pkg.sv ====
package fpu_pkg;

  // ####################
  // Single-precision format.
  // ####################
  localparam int FP_WIDTH   = 32;
  localparam int EXP_WIDTH  = 8;
  localparam int MANT_WIDTH = 23;
  localparam int EXP_BIAS   = 127;

  typedef logic [FP_WIDTH-1:0] fp_word_t;

  // Lane opcodes, as carried on the lane_op ports.
  typedef enum logic [3:0] {
    OP_NOP   = 4'd0,
    OP_ABS   = 4'd1,
    OP_NEG   = 4'd2,
    OP_MIN   = 4'd3,
    OP_MAX   = 4'd4,
    OP_CMPLT = 4'd5,
    OP_CVT   = 4'd6
  } fpu_op_e;

  typedef enum logic [0:0] {
    RND_TRUNC   = 1'b0,
    RND_NEAREST = 1'b1
  } rnd_mode_e;

  // Per-conversion exception flags.
  typedef struct packed {
    logic invalid;
    logic inexact;
  } cvt_flags_t;

  // Saturation results of float to int32.
  localparam fp_word_t INT_MAX_WORD = 32'h7fff_ffff;
  localparam fp_word_t INT_MIN_WORD = 32'h8000_0000;

endpackage
